/* filelist.f */
hdl/rasterPkg.sv
hdl/commandParser.sv
hdl/pixelScanner.sv
hdl/colorBuffer.sv
hdl/rasterTop.sv
sim/clockGen.sv
sim/rasterTb.sv

/* run.sh */
#!/bin/sh
# Build the raster back end testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module rasterTb -f filelist.f -o rasterSim \
    && ./obj_dir/rasterSim 2>&1 | tee sim.log
grep -qx "TESTBENCH PASSED" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

/* sim/rasterTb.sv */
////////////////////////////////////////////////////////////////////////////
// Tile rasterizer testbench
// Random command traffic against a reference frame model, with the
// framebuffer stream checked word by word on every commit
////////////////////////////////////////////////////////////////////////////

module rasterTb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int ReadyTimeout  = 1000;
    localparam int CommitTimeout = 4000;
    localparam int FrameWords    = rasterPkg::ScreenSize * rasterPkg::ScreenSize;

    logic                aclk;
    logic                rstN;
    logic                cmdValid;
    logic                cmdReady;
    logic                cmdLast;
    rasterPkg::cmdWord_t cmdData;
    logic                fbValid;
    logic                fbReady = 1'b0;
    logic                fbLast;
    rasterPkg::pixel_t   fbData;
    logic                busy;

    int seed = 32'h6ffbb011;

    // Reference frame and configuration registers
    rasterPkg::pixel_t     model [FrameWords];
    rasterPkg::pixel_t     drawColor;
    rasterPkg::pixel_t     clearColor;
    rasterPkg::colorMask_t drawMask;

    // Stream bookkeeping
    logic stallMode    = 1'b0;
    int   wordCount    = 0;
    int   allowedWords = 0;

    clockGen clock_i (
        .aclk(aclk),
        .rstN(rstN)
    );

    rasterTop dut_i (
        .aclk(aclk),
        .rstN(rstN),
        .cmdValid(cmdValid),
        .cmdReady(cmdReady),
        .cmdLast(cmdLast),
        .cmdData(cmdData),
        .fbValid(fbValid),
        .fbReady(fbReady),
        .fbLast(fbLast),
        .fbData(fbData),
        .busy(busy)
    );

    task automatic reportFailure(input string what);
        $display("%s", what);
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////////
    function automatic rasterPkg::pixel_t mergePixel(input rasterPkg::pixel_t old,
                                                     input rasterPkg::pixel_t color,
                                                     input rasterPkg::colorMask_t mask);
        rasterPkg::pixel_t result;
        result = old;
        if (mask[3]) result[15:12] = color[15:12];
        if (mask[2]) result[11:8] = color[11:8];
        if (mask[1]) result[7:4] = color[7:4];
        if (mask[0]) result[3:0] = color[3:0];
        return result;
    endfunction

    // Inclusive bounds with nothing written when x1 < x0 or y1 < y0
    function automatic void fillModel(input rasterPkg::cmdWord_t rect);
        int x0;
        int y0;
        int x1;
        int y1;
        x0 = int'(rect[15:12]);
        y0 = int'(rect[11:8]);
        x1 = int'(rect[7:4]);
        y1 = int'(rect[3:0]);
        for (int y = y0; y <= y1; y++) begin
            for (int x = x0; x <= x1; x++) begin
                model[y * rasterPkg::ScreenSize + x] =
                    mergePixel(model[y * rasterPkg::ScreenSize + x], drawColor, drawMask);
            end
        end
    endfunction

    function automatic void clearModel();
        foreach (model[i]) model[i] = clearColor;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Command and stream drivers
    ////////////////////////////////////////////////////////////////////////////
    // Returns at the falling edge before the transfer edge
    task automatic sendWord(input rasterPkg::cmdWord_t word);
        int gap;
        int waited;
        gap = $random(seed) & 3;
        @(posedge aclk);
        if (gap > 0) begin
            cmdValid <= 1'b0;
            repeat (gap) @(posedge aclk);
        end
        cmdData  <= word;
        cmdValid <= 1'b1;
        waited = 0;
        @(negedge aclk);
        while (!cmdReady && waited < ReadyTimeout) begin
            waited++;
            @(negedge aclk);
        end
        assert (cmdReady) else reportFailure("timeout while waiting for cmdReady");
    endtask

    task automatic waitIdle();
        int waited;
        waited = 0;
        @(negedge aclk);
        while ((busy || !cmdReady) && waited < ReadyTimeout) begin
            waited++;
            @(negedge aclk);
        end
        assert (!busy && cmdReady) else
            reportFailure("timeout while waiting for the DUT to go idle");
    endtask

    task automatic runCommit(input logic withStalls);
        int waited;
        stallMode <= withStalls;
        sendWord({rasterPkg::OpCommit, 12'h000});
        @(posedge aclk);
        cmdValid <= 1'b0;
        allowedWords = allowedWords + FrameWords;
        waited = 0;
        while (wordCount < allowedWords && waited < CommitTimeout) begin
            waited++;
            @(posedge aclk);
        end
        assert (wordCount == allowedWords) else
            reportFailure("timeout before the whole frame was streamed");
        waitIdle();
        stallMode <= 1'b0;
    endtask

    // Random back-pressure only while a stalled commit runs
    always @(posedge aclk) begin
        if (stallMode) fbReady <= ($random(seed) & 1) != 0;
        else fbReady <= 1'b1;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stream and handshake checks
    ////////////////////////////////////////////////////////////////////////////
    always @(negedge aclk) begin : streamCheck
        int pixel;
        if (rstN === 1'b1 && cmdValid && cmdReady) begin
            assert (!busy) else reportFailure("command word accepted while busy was high");
        end
        if (rstN === 1'b1 && fbValid && fbReady) begin
            pixel = wordCount % FrameWords;
            assert (wordCount < allowedWords) else
                reportFailure("framebuffer word sent outside a commit");
            assert (fbData === model[pixel]) else reportFailure($sformatf(
                "mismatch at %0t: fbData pixel %0d expected %h actual %h",
                $time, pixel, model[pixel], fbData));
            assert (fbLast === (pixel == FrameWords - 1)) else reportFailure($sformatf(
                "mismatch at %0t: fbLast pixel %0d expected %b actual %b",
                $time, pixel, pixel == FrameWords - 1, fbLast));
            wordCount++;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////////////
    initial begin
        rasterPkg::pixel_t     color;
        rasterPkg::colorMask_t mask;
        rasterPkg::cmdWord_t   rect;
        logic [3:0]            op;
        int                    waited;

        cmdValid   = 1'b0;
        cmdLast    = 1'b0;
        cmdData    = '0;
        drawColor  = '0;
        clearColor = '0;
        drawMask   = '1;
        foreach (model[i]) model[i] = '0;

        waited = 0;
        while (rstN !== 1'b1 && waited < 20) begin
            waited++;
            @(negedge aclk);
        end
        assert (rstN === 1'b1) else reportFailure("reset was never released");
        assert (fbValid === 1'b0) else reportFailure($sformatf(
            "mismatch at %0t: fbValid expected 0 actual %b", $time, fbValid));
        assert (busy === 1'b0) else reportFailure($sformatf(
            "mismatch at %0t: busy expected 0 actual %b", $time, busy));
        waitIdle();

        // Clear to a fresh color and stream it out
        color = 16'($random(seed));
        sendWord({rasterPkg::OpClear, 12'h001});
        sendWord(color);
        clearColor = color;
        clearModel();
        runCommit(1'b0);

        // Masked fills with a share of empty rectangles
        for (int n = 0; n < 40; n++) begin
            color = 16'($random(seed));
            mask  = 4'($random(seed));
            rect  = 16'($random(seed));
            if (($random(seed) & 3) != 0) begin
                if (rect[7:4] < rect[15:12]) begin
                    rect = {rect[7:4], rect[11:8], rect[15:12], rect[3:0]};
                end
                if (rect[3:0] < rect[11:8]) begin
                    rect = {rect[15:12], rect[3:0], rect[7:4], rect[11:8]};
                end
            end
            sendWord({rasterPkg::OpSetColor, 12'h000});
            sendWord(color);
            drawColor = color;
            sendWord({rasterPkg::OpSetMask, 8'h00, mask});
            drawMask = mask;
            sendWord({rasterPkg::OpFillRect, 12'h000});
            sendWord(rect);
            fillModel(rect);
        end
        runCommit(1'b0);

        // Same frame under back-pressure
        runCommit(1'b1);

        // Unknown opcodes are swallowed
        for (int n = 0; n < 12; n++) begin
            op = 4'($random(seed));
            if (op >= 4'd1 && op <= 4'd5) op = op + 4'd5;
            sendWord({op, 12'($random(seed))});
        end
        runCommit(1'b0);

        // Clear with the stored color while a partial mask is set
        mask = 4'($random(seed)) & 4'h7;
        sendWord({rasterPkg::OpSetMask, 8'h00, mask});
        drawMask = mask;
        sendWord({rasterPkg::OpClear, 12'h000});
        clearModel();
        runCommit(1'b1);

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

/* sim/clockGen.sv */
////////////////////////////////////////////////////////////////////////////
// Testbench clock and reset
// 8 ns clock, active low reset held for the first 4 cycles
////////////////////////////////////////////////////////////////////////////

module clockGen (
    output logic aclk,
    output logic rstN
);

    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        aclk = 1'b0;
        forever #4 aclk = ~aclk;
    end

    initial begin
        rstN = 1'b0;
        repeat (4) @(posedge aclk);
        rstN <= 1'b1;
    end

endmodule

/* hdl/rasterTop.sv */
////////////////////////////////////////////////////////////////////////////
// Tile rasterizer top level
// Command stream in, rectangle fill and clear into the tile buffer,
// framebuffer stream out on commit
////////////////////////////////////////////////////////////////////////////

module rasterTop (
    input  logic                aclk,
    input  logic                rstN,

    // Command stream
    input  logic                cmdValid,
    output logic                cmdReady,
    input  logic                cmdLast,
    input  rasterPkg::cmdWord_t cmdData,

    // Framebuffer stream
    output logic                fbValid,
    input  logic                fbReady,
    output logic                fbLast,
    output rasterPkg::pixel_t   fbData,

    output logic                busy
);

    // Framing comes from the opcodes, cmdLast carries no meaning here

    ////////////////////////////////////////////////////////////////////////////
    // Internal wiring
    ////////////////////////////////////////////////////////////////////////////
    logic                   scanStart;
    rasterPkg::coord_t      scanX0;
    rasterPkg::coord_t      scanY0;
    rasterPkg::coord_t      scanX1;
    rasterPkg::coord_t      scanY1;
    rasterPkg::pixelIndex_t scanIndex;
    logic                   scanValid;
    logic                   scanLast;
    logic                   scanDone;
    logic                   scanStall;
    rasterPkg::scanMode_t   scanMode;
    rasterPkg::pixel_t      writeColor;
    rasterPkg::colorMask_t  writeMask;

    commandParser parser_i (
        .aclk(aclk),
        .rstN(rstN),
        .cmdValid(cmdValid),
        .cmdReady(cmdReady),
        .cmdData(cmdData),
        .scanStart(scanStart),
        .scanX0(scanX0),
        .scanY0(scanY0),
        .scanX1(scanX1),
        .scanY1(scanY1),
        .scanDone(scanDone),
        .scanMode(scanMode),
        .writeColor(writeColor),
        .writeMask(writeMask),
        .fbValid(fbValid),
        .fbReady(fbReady),
        .fbLast(fbLast),
        .busy(busy)
    );

    pixelScanner scanner_i (
        .aclk(aclk),
        .rstN(rstN),
        .scanStart(scanStart),
        .scanX0(scanX0),
        .scanY0(scanY0),
        .scanX1(scanX1),
        .scanY1(scanY1),
        .scanStall(scanStall),
        .scanIndex(scanIndex),
        .scanValid(scanValid),
        .scanLast(scanLast),
        .scanDone(scanDone)
    );

    colorBuffer buffer_i (
        .aclk(aclk),
        .rstN(rstN),
        .scanIndex(scanIndex),
        .scanValid(scanValid),
        .scanLast(scanLast),
        .scanMode(scanMode),
        .writeColor(writeColor),
        .writeMask(writeMask),
        .scanStall(scanStall),
        .fbValid(fbValid),
        .fbReady(fbReady),
        .fbLast(fbLast),
        .fbData(fbData)
    );

endmodule

/* hdl/colorBuffer.sv */
////////////////////////////////////////////////////////////////////////////
// Color buffer
// 16x16 RGBA4444 pixel memory with masked read-modify-write for fill
// and clear, and a two-stage read path feeding the framebuffer stream
////////////////////////////////////////////////////////////////////////////

module colorBuffer (
    input  logic                   aclk,
    input  logic                   rstN,

    input  rasterPkg::pixelIndex_t scanIndex,
    input  logic                   scanValid,
    input  logic                   scanLast,

    input  rasterPkg::scanMode_t   scanMode,
    input  rasterPkg::pixel_t      writeColor,
    input  rasterPkg::colorMask_t  writeMask,

    output logic                   scanStall,

    output logic                   fbValid,
    input  logic                   fbReady,
    output logic                   fbLast,
    output rasterPkg::pixel_t      fbData
);

    rasterPkg::pixel_t mem [rasterPkg::ScreenSize * rasterPkg::ScreenSize];

    logic                   accept;
    logic                   isCommit;

    // Read stage
    rasterPkg::pixel_t      readData;
    logic                   readValid;
    logic                   readLast;

    // Write-back of the masked merge
    logic                   wrValid;
    rasterPkg::pixelIndex_t wrIndex;
    rasterPkg::pixel_t      wrColor;
    rasterPkg::colorMask_t  wrMask;
    rasterPkg::pixel_t      merged;

    // The whole read path freezes while the stream is back-pressured
    assign scanStall = fbValid && !fbReady;
    assign accept    = scanValid && !scanStall;
    assign isCommit  = (scanMode == rasterPkg::ModeCommit);

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            merged[4*i +: 4] = wrMask[i] ? wrColor[4*i +: 4] : readData[4*i +: 4];
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Memory and data path
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge aclk) begin
        if (!scanStall) begin
            readData <= mem[scanIndex];
            wrIndex  <= scanIndex;
            wrColor  <= writeColor;
            wrMask   <= writeMask;
            fbData   <= readData;
        end
        if (wrValid) begin
            mem[wrIndex] <= merged;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stage valid flags
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge aclk or negedge rstN) begin
        if (!rstN) begin
            wrValid   <= 1'b0;
            readValid <= 1'b0;
            readLast  <= 1'b0;
            fbValid   <= 1'b0;
            fbLast    <= 1'b0;
        end else begin
            wrValid <= accept && !isCommit;
            if (!scanStall) begin
                readValid <= accept && isCommit;
                readLast  <= accept && isCommit && scanLast;
                fbValid   <= readValid;
                fbLast    <= readLast;
            end
        end
    end

endmodule

/* hdl/pixelScanner.sv */
////////////////////////////////////////////////////////////////////////////
// Pixel scanner
// Walks a rectangle in row-major order, one buffer index per cycle,
// holding position while the buffer stalls
////////////////////////////////////////////////////////////////////////////

module pixelScanner (
    input  logic                   aclk,
    input  logic                   rstN,

    input  logic                   scanStart,
    input  rasterPkg::coord_t      scanX0,
    input  rasterPkg::coord_t      scanY0,
    input  rasterPkg::coord_t      scanX1,
    input  rasterPkg::coord_t      scanY1,

    input  logic                   scanStall,

    output rasterPkg::pixelIndex_t scanIndex,
    output logic                   scanValid,
    output logic                   scanLast,
    output logic                   scanDone
);

    rasterPkg::coord_t curX;
    rasterPkg::coord_t curY;
    rasterPkg::coord_t startX;
    rasterPkg::coord_t endX;
    rasterPkg::coord_t endY;

    logic rowEnd;
    logic step;

    assign rowEnd = (curX == endX);
    assign step   = scanValid && !scanStall;

    // Row-major index, y * 16 + x
    assign scanIndex = rasterPkg::pixelIndex_t'({curY, curX});
    assign scanLast  = scanValid && rowEnd && (curY == endY);
    assign scanDone  = step && scanLast;

    ////////////////////////////////////////////////////////////////////////////
    // Run flag
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge aclk or negedge rstN) begin
        if (!rstN) begin
            scanValid <= 1'b0;
        end else if (scanStart) begin
            scanValid <= 1'b1;
        end else if (scanDone) begin
            scanValid <= 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Coordinate counters
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge aclk) begin
        if (scanStart) begin
            curX   <= scanX0;
            curY   <= scanY0;
            startX <= scanX0;
            endX   <= scanX1;
            endY   <= scanY1;
        end else if (step && !scanLast) begin
            if (rowEnd) begin
                // Wrap to the left edge of the next row
                curX <= startX;
                curY <= curY + 1'b1;
            end else begin
                curX <= curX + 1'b1;
            end
        end
    end

endmodule

/* hdl/commandParser.sv */
////////////////////////////////////////////////////////////////////////////
// Command parser
// Decodes the command stream, keeps draw color, clear color and mask,
// and launches fill, clear and commit scans
////////////////////////////////////////////////////////////////////////////

module commandParser (
    input  logic                  aclk,
    input  logic                  rstN,

    input  logic                  cmdValid,
    output logic                  cmdReady,
    input  rasterPkg::cmdWord_t   cmdData,

    output logic                  scanStart,
    output rasterPkg::coord_t     scanX0,
    output rasterPkg::coord_t     scanY0,
    output rasterPkg::coord_t     scanX1,
    output rasterPkg::coord_t     scanY1,
    input  logic                  scanDone,

    output rasterPkg::scanMode_t  scanMode,
    output rasterPkg::pixel_t     writeColor,
    output rasterPkg::colorMask_t writeMask,

    input  logic                  fbValid,
    input  logic                  fbReady,
    input  logic                  fbLast,

    output logic                  busy
);

    rasterPkg::parserState_t state;
    rasterPkg::parserState_t stateNext;

    rasterPkg::pixel_t     drawColor;
    rasterPkg::pixel_t     clearColor;
    rasterPkg::colorMask_t drawMask;

    logic              cmdAccept;
    logic [3:0]        opcode;
    logic              startScan;
    logic              rectEmpty;
    rasterPkg::coord_t rectX0;
    rasterPkg::coord_t rectY0;
    rasterPkg::coord_t rectX1;
    rasterPkg::coord_t rectY1;

    assign cmdAccept = cmdValid && cmdReady;
    assign opcode    = cmdData[15:12];

    // Rectangle word, x0 y0 x1 y1 from the top nibble down
    assign rectX0    = cmdData[15:12];
    assign rectY0    = cmdData[11:8];
    assign rectX1    = cmdData[7:4];
    assign rectY1    = cmdData[3:0];
    assign rectEmpty = (rectX1 < rectX0) || (rectY1 < rectY0);

    ////////////////////////////////////////////////////////////////////////////
    // Next state
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        stateNext = state;
        case (state)
            rasterPkg::Idle: begin
                if (cmdAccept) begin
                    case (opcode)
                        rasterPkg::OpSetColor: stateNext = rasterPkg::Color;
                        rasterPkg::OpFillRect: stateNext = rasterPkg::RectWord;
                        rasterPkg::OpClear:
                            stateNext = cmdData[0] ? rasterPkg::ClearColor : rasterPkg::Scan;
                        rasterPkg::OpCommit:   stateNext = rasterPkg::Scan;
                        // Mask updates and unknown opcodes stay here
                        default:               stateNext = rasterPkg::Idle;
                    endcase
                end
            end
            rasterPkg::Color: begin
                if (cmdAccept) stateNext = rasterPkg::Idle;
            end
            rasterPkg::ClearColor: begin
                if (cmdAccept) stateNext = rasterPkg::Scan;
            end
            rasterPkg::RectWord: begin
                if (cmdAccept) stateNext = rectEmpty ? rasterPkg::Idle : rasterPkg::Scan;
            end
            rasterPkg::Scan: begin
                if (scanDone) begin
                    stateNext = (scanMode == rasterPkg::ModeCommit) ?
                                rasterPkg::Drain : rasterPkg::Idle;
                end
            end
            rasterPkg::Drain: begin
                // Hold off commands until the last framebuffer word is taken
                if (fbValid && fbReady && fbLast) stateNext = rasterPkg::Idle;
            end
            default: stateNext = rasterPkg::Idle;
        endcase
    end

    assign startScan = (stateNext == rasterPkg::Scan) && (state != rasterPkg::Scan);

    ////////////////////////////////////////////////////////////////////////////
    // Control and configuration registers
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge aclk or negedge rstN) begin
        if (!rstN) begin
            state      <= rasterPkg::Idle;
            cmdReady   <= 1'b0;
            busy       <= 1'b0;
            scanStart  <= 1'b0;
            scanMode   <= rasterPkg::ModeFill;
            drawColor  <= '0;
            clearColor <= '0;
            drawMask   <= '1;
        end else begin
            state     <= stateNext;
            cmdReady  <= (stateNext != rasterPkg::Scan) && (stateNext != rasterPkg::Drain);
            busy      <= (stateNext == rasterPkg::Scan) || (stateNext == rasterPkg::Drain);
            scanStart <= startScan;
            if (startScan) begin
                if (state == rasterPkg::RectWord) begin
                    scanMode <= rasterPkg::ModeFill;
                end else if (state == rasterPkg::Idle && opcode == rasterPkg::OpCommit) begin
                    scanMode <= rasterPkg::ModeCommit;
                end else begin
                    scanMode <= rasterPkg::ModeClear;
                end
            end
            if (cmdAccept) begin
                case (state)
                    rasterPkg::Idle: begin
                        if (opcode == rasterPkg::OpSetMask) drawMask <= cmdData[3:0];
                    end
                    rasterPkg::Color:      drawColor  <= cmdData;
                    rasterPkg::ClearColor: clearColor <= cmdData;
                    default: ;
                endcase
            end
        end
    end

    // Scan bounds, full screen unless a rectangle is being filled
    always_ff @(posedge aclk) begin
        if (startScan) begin
            if (state == rasterPkg::RectWord) begin
                scanX0 <= rectX0;
                scanY0 <= rectY0;
                scanX1 <= rectX1;
                scanY1 <= rectY1;
            end else begin
                scanX0 <= '0;
                scanY0 <= '0;
                scanX1 <= rasterPkg::coord_t'(rasterPkg::ScreenSize - 1);
                scanY1 <= rasterPkg::coord_t'(rasterPkg::ScreenSize - 1);
            end
        end
    end

    // Clear always writes every channel
    assign writeColor = (scanMode == rasterPkg::ModeClear) ? clearColor : drawColor;
    assign writeMask  = (scanMode == rasterPkg::ModeClear) ? '1 : drawMask;

endmodule

/* hdl/rasterPkg.sv */
////////////////////////////////////////////////////////////////////////////
// Raster back end shared definitions
// Screen size, data widths, command opcodes and the parser state
// encoding used by the tile rasterizer blocks
////////////////////////////////////////////////////////////////////////////

package rasterPkg;

    ////////////////////////////////////////////////////////////////////////////
    // Resolution and widths
    ////////////////////////////////////////////////////////////////////////////
    localparam int ScreenSize = 16;
    localparam int CoordWidth = 4;
    localparam int IndexWidth = 8;

    typedef logic [CoordWidth-1:0] coord_t;
    typedef logic [IndexWidth-1:0] pixelIndex_t;
    // RGBA4444, R in the top nibble
    typedef logic [15:0]           pixel_t;
    typedef logic [15:0]           cmdWord_t;
    // One enable per channel nibble, R in bit 3
    typedef logic [3:0]            colorMask_t;

    ////////////////////////////////////////////////////////////////////////////
    // Command opcodes, header bits 15..12
    ////////////////////////////////////////////////////////////////////////////
    localparam logic [3:0] OpSetColor = 4'd1;
    localparam logic [3:0] OpSetMask  = 4'd2;
    localparam logic [3:0] OpFillRect = 4'd3;
    localparam logic [3:0] OpClear    = 4'd4;
    localparam logic [3:0] OpCommit   = 4'd5;

    // Purpose of the running scan
    typedef logic [1:0] scanMode_t;
    localparam scanMode_t ModeFill   = 2'd0;
    localparam scanMode_t ModeClear  = 2'd1;
    localparam scanMode_t ModeCommit = 2'd2;

    typedef enum logic [2:0] {
        Idle,
        Color,
        ClearColor,
        RectWord,
        Scan,
        Drain
    } parserState_t;

endpackage
